// ==== hw/dmb_consts.svh ====
`ifndef DMB_CONSTS_SVH
`define DMB_CONSTS_SVH

// Board geometry
`define DMB_NCFEB         5

// Power-up sequencing, in clkcms cycles after clr0 drops
`define DMB_RST_CYCLES    16
`define DMB_READY_CYCLES  32

// LCT to L1A latency counter
`define DMB_TM_WIDTH      8

// APB slave
`define DMB_APB_AW        8
`define DMB_APB_DW        32
`define DMB_ADDR_CFG      8'h00
`define DMB_ADDR_TIMER    8'h04
`define DMB_ADDR_STATUS   8'h08

`endif

// ==== hw/dmb_pkg.sv ====
package dmb_pkg;

`include "dmb_consts.svh"

	// One bit per CFEB, bit 0 is CFEB 1
	typedef logic [`DMB_NCFEB-1:0] cfeb_vec_t;

	typedef logic [`DMB_TM_WIDTH-1:0] tm_count_t;

	// CCB calibration lines, active low
	// [2] pedestal (not used here), [1] inject, [0] pulse
	typedef logic [2:0] ccbcal_t;

	// APB bus words
	typedef logic [`DMB_APB_AW-1:0] apb_addr_t;
	typedef logic [`DMB_APB_DW-1:0] apb_data_t;

endpackage

// ==== hw/dmb_ifs.sv ====
`timescale 1ns/1ps

////////////////////
// Configuration bus
////////////////////

interface cfg_if import dmb_pkg::*; ();
	logic      dp_rst;
	logic      cable_dly;
	logic      alt_en;
	cfeb_vec_t cfeb_en;

	modport ctrl (
		output dp_rst,
		output cfeb_en,
		output cable_dly,
		output alt_en
	);

	modport dp (
		input dp_rst,
		input cfeb_en,
		input cable_dly,
		input alt_en
	);
endinterface

////////////////////
// Latency timer bus
////////////////////

interface tmr_if import dmb_pkg::*; ();
	logic      holdoff;
	logic      clr;
	logic      valid;
	tm_count_t count;

	modport ctrl (output holdoff, output clr, input count, input valid);
	modport tmr (input holdoff, input clr, output count, output valid);
endinterface

// ==== hw/board_ctrl.sv ====
`timescale 1ns/1ps
`include "dmb_consts.svh"

module board_ctrl
	import dmb_pkg::*;
(
	input  logic      clkcms,
	input  logic      clr0,
	input  logic      psel_i,
	input  logic      penable_i,
	input  logic      pwrite_i,
	input  apb_addr_t paddr_i,
	input  apb_data_t pwdata_i,
	output apb_data_t prdata_o,
	output logic      pready_o,
	output logic      pslverr_o,
	output logic      ctrl_ready_o,
	cfg_if.ctrl       cfg,
	tmr_if.ctrl       tmr
);

	localparam int CNT_W = $clog2(`DMB_READY_CYCLES + 1);

	logic [CNT_W-1:0] rst_cnt;
	logic             ready;
	logic             access;
	logic             hit_cfg;
	logic             hit_tmr;
	logic             hit_sts;
	logic             err;
	logic             wr_ok;
	cfeb_vec_t        cfeb_en_q;
	logic             cable_dly_q;
	logic             alt_en_q;
	apb_data_t        rdata;

	////////////////////
	// Power-up sequence
	////////////////////

	// Counts edges after clr0 drops, parks at the ready count
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
			rst_cnt <= '0;
		else if (rst_cnt != CNT_W'(`DMB_READY_CYCLES))
			rst_cnt <= rst_cnt + 1'b1;
	end

	assign ready        = (rst_cnt == CNT_W'(`DMB_READY_CYCLES));
	assign ctrl_ready_o = ready;
	assign cfg.dp_rst   = (rst_cnt < CNT_W'(`DMB_RST_CYCLES));

	// Timers stay parked until the board is up
	assign tmr.holdoff = ~ready;

	////////////////////
	// APB register file
	////////////////////

	assign access  = psel_i & penable_i;
	assign hit_cfg = (paddr_i == `DMB_ADDR_CFG);
	assign hit_tmr = (paddr_i == `DMB_ADDR_TIMER);
	assign hit_sts = (paddr_i == `DMB_ADDR_STATUS);

	// Unmapped address, or an attempt to write STATUS
	assign err   = access & (~(hit_cfg | hit_tmr | hit_sts) | (pwrite_i & hit_sts));
	assign wr_ok = access & pwrite_i & ~err;

	assign pready_o  = access;
	assign pslverr_o = err;

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			cfeb_en_q   <= '1;
			cable_dly_q <= 1'b0;
			alt_en_q    <= 1'b0;
		end
		else if (wr_ok && hit_cfg)
		begin
			cfeb_en_q   <= pwdata_i[`DMB_NCFEB-1:0];
			cable_dly_q <= pwdata_i[`DMB_NCFEB];
			alt_en_q    <= pwdata_i[`DMB_NCFEB+1];
		end
	end

	assign cfg.cfeb_en   = cfeb_en_q;
	assign cfg.cable_dly = cable_dly_q;
	assign cfg.alt_en    = alt_en_q;

	// Any write data to TIMER clears it
	assign tmr.clr = wr_ok & hit_tmr;

	always_comb
	begin
		rdata = '0;
		if (hit_cfg)
		begin
			rdata[`DMB_NCFEB-1:0] = cfeb_en_q;
			rdata[`DMB_NCFEB]     = cable_dly_q;
			rdata[`DMB_NCFEB+1]   = alt_en_q;
		end
		else if (hit_tmr)
		begin
			rdata[`DMB_TM_WIDTH-1:0] = tmr.count;
			rdata[`DMB_TM_WIDTH]     = tmr.valid;
		end
		else if (hit_sts)
			rdata[0] = ready;
	end

	assign prdata_o = rdata;

	// A response needs a setup cycle right before it
	a_apb_access: assert property (@(posedge clkcms) disable iff (clr0)
		(pready_o || pslverr_o) |-> (psel_i && penable_i && $past(psel_i && !penable_i)));

endmodule

// ==== hw/trig_enc_out.sv ====
`timescale 1ns/1ps

module trig_enc_out
	import dmb_pkg::*;
(
	input  logic      clkcms,
	input  logic      clr0,
	input  cfeb_vec_t pre_lct_i,
	input  cfeb_vec_t l1a_match_i,
	input  logic      l1a_cfeb_i,
	cfg_if.dp         cfg,
	output cfeb_vec_t trg_enc_b0_o,
	output cfeb_vec_t trg_enc_b1_o,
	output cfeb_vec_t trg_enc_b2_o
);

	// Index is the code bit, each entry one bit per CFEB
	cfeb_vec_t [2:0] code_d;
	cfeb_vec_t [2:0] code_q;
	cfeb_vec_t [2:0] code_dly_q;
	cfeb_vec_t [2:0] out_q;

	// Code bits, masked per CFEB
	assign code_d[0] = pre_lct_i & cfg.cfeb_en;
	assign code_d[1] = l1a_match_i & cfg.cfeb_en;
	assign code_d[2] = l1a_cfeb_i ? cfg.cfeb_en : '0;

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			code_q     <= '0;
			code_dly_q <= '0;
			out_q      <= '0;
		end
		else if (cfg.dp_rst)
		begin
			code_q     <= '0;
			code_dly_q <= '0;
			out_q      <= '0;
		end
		else
		begin
			code_q     <= code_d;
			code_dly_q <= code_q;
			// Extra cable cycle for the long FEB runs
			out_q      <= cfg.cable_dly ? code_dly_q : code_q;
		end
	end

	assign trg_enc_b0_o = out_q[0];
	assign trg_enc_b1_o = out_q[1];
	assign trg_enc_b2_o = out_q[2];

endmodule

// ==== hw/cal_pulse_gen.sv ====
`timescale 1ns/1ps

module cal_pulse_gen
	import dmb_pkg::*;
(
	input  logic    clkcms,
	input  logic    clr0,
	input  ccbcal_t ccbcal_i,
	cfg_if.dp       cfg,
	output logic    inj_pulse_o,
	output logic    ext_pulse_o
);

	logic inj_s1;
	logic inj_s2;
	logic pls_s1;
	logic pls_s2;
	logic pls_s3;
	logic req;
	logic pass;
	logic pass_q;
	logic pass_d1;
	logic phase_q;
	logic ext_q;

	// CCB lines are active low, flipped at the first flop
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			inj_s1 <= 1'b0;
			inj_s2 <= 1'b0;
			pls_s1 <= 1'b0;
			pls_s2 <= 1'b0;
			pls_s3 <= 1'b0;
		end
		else
		begin
			inj_s1 <= ~ccbcal_i[1];
			inj_s2 <= inj_s1;
			pls_s1 <= ~ccbcal_i[0];
			pls_s2 <= pls_s1;
			pls_s3 <= pls_s2;
		end
	end

	assign req  = pls_s2 & ~pls_s3;
	// Alternate mode lets every other request through
	assign pass = req & (~cfg.alt_en | ~phase_q);

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
			phase_q <= 1'b0;
		else if (cfg.dp_rst || !cfg.alt_en)
			phase_q <= 1'b0;
		else if (req)
			phase_q <= ~phase_q;
	end

	// Two-cycle stretcher
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			pass_q  <= 1'b0;
			pass_d1 <= 1'b0;
			ext_q   <= 1'b0;
		end
		else
		begin
			pass_q  <= pass;
			pass_d1 <= pass_q;
			ext_q   <= pass_q | pass_d1;
		end
	end

	assign inj_pulse_o = inj_s2;
	assign ext_pulse_o = ext_q;

	// One request is good for two high cycles, no more
	a_ext_width: assert property (@(posedge clkcms) disable iff (clr0)
		(ext_pulse_o && $past(ext_pulse_o)) |=> !ext_pulse_o);

endmodule

// ==== hw/lct_l1a_timer.sv ====
`timescale 1ns/1ps

module lct_l1a_timer
	import dmb_pkg::*;
(
	input  logic clkcms,
	input  logic clr0,
	input  logic start_i,
	input  logic stop_i,
	tmr_if.tmr   tmr
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_RUN  = 2'd1;
	localparam logic [1:0] ST_DONE = 2'd2;

	logic [1:0] state_q;
	logic       start_d;
	logic       start_rise;
	tm_count_t  count_q;

	assign start_rise = start_i & ~start_d;

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			state_q <= ST_IDLE;
			start_d <= 1'b0;
			count_q <= '0;
		end
		else
		begin
			start_d <= start_i;
			if (tmr.clr)
			begin
				state_q <= ST_IDLE;
				count_q <= '0;
			end
			else
				case (state_q)
					ST_IDLE:
						if (start_rise && !tmr.holdoff)
						begin
							state_q <= ST_RUN;
							count_q <= '0;
						end
					ST_RUN:
					begin
						// Saturate at full scale
						if (count_q != '1)
							count_q <= count_q + 1'b1;
						if (stop_i)
							state_q <= ST_DONE;
					end
					ST_DONE:
						state_q <= ST_DONE;
					default:
						state_q <= ST_IDLE;
				endcase
		end
	end

	assign tmr.count = count_q;
	assign tmr.valid = (state_q == ST_DONE);

	// Latched latency is frozen until the next clear
	a_count_hold: assert property (@(posedge clkcms) disable iff (clr0)
		(tmr.valid && $past(tmr.valid)) |-> $stable(tmr.count));

endmodule

// ==== hw/dmb_trig_top.sv ====
`timescale 1ns/1ps

module dmb_trig_top
	import dmb_pkg::*;
(
	input  logic      clkcms,
	input  logic      clr0,
	// APB slave
	input  logic      psel_i,
	input  logic      penable_i,
	input  logic      pwrite_i,
	input  apb_addr_t paddr_i,
	input  apb_data_t pwdata_i,
	output apb_data_t prdata_o,
	output logic      pready_o,
	output logic      pslverr_o,
	// Trigger inputs
	input  cfeb_vec_t pre_lct_i,
	input  cfeb_vec_t l1a_match_i,
	input  logic      l1a_cfeb_i,
	input  ccbcal_t   ccbcal_i,
	// To the FEBs and the pulser
	output cfeb_vec_t trg_enc_b0_o,
	output cfeb_vec_t trg_enc_b1_o,
	output cfeb_vec_t trg_enc_b2_o,
	output logic      inj_pulse_o,
	output logic      ext_pulse_o,
	output logic      ctrl_ready_o
);

	cfg_if cfg_bus ();
	tmr_if tmr_bus ();

	board_ctrl u_board_ctrl (
		.clkcms       (clkcms),
		.clr0         (clr0),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pwrite_i     (pwrite_i),
		.paddr_i      (paddr_i),
		.pwdata_i     (pwdata_i),
		.prdata_o     (prdata_o),
		.pready_o     (pready_o),
		.pslverr_o    (pslverr_o),
		.ctrl_ready_o (ctrl_ready_o),
		.cfg          (cfg_bus.ctrl),
		.tmr          (tmr_bus.ctrl)
	);

	trig_enc_out u_trig_enc_out (
		.clkcms       (clkcms),
		.clr0         (clr0),
		.pre_lct_i    (pre_lct_i),
		.l1a_match_i  (l1a_match_i),
		.l1a_cfeb_i   (l1a_cfeb_i),
		.cfg          (cfg_bus.dp),
		.trg_enc_b0_o (trg_enc_b0_o),
		.trg_enc_b1_o (trg_enc_b1_o),
		.trg_enc_b2_o (trg_enc_b2_o)
	);

	cal_pulse_gen u_cal_pulse_gen (
		.clkcms      (clkcms),
		.clr0        (clr0),
		.ccbcal_i    (ccbcal_i),
		.cfg         (cfg_bus.dp),
		.inj_pulse_o (inj_pulse_o),
		.ext_pulse_o (ext_pulse_o)
	);

	// Latency from the first CFEB pre-LCT to the common L1A
	lct_l1a_timer u_lct_l1a_timer (
		.clkcms  (clkcms),
		.clr0    (clr0),
		.start_i (pre_lct_i[0]),
		.stop_i  (l1a_cfeb_i),
		.tmr     (tmr_bus.tmr)
	);

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
	parameter real PERIOD_NS = 40.0
) (
	output logic clk_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

endmodule

// ==== tb/tb_dmb_top.sv ====
`timescale 1ns/1ps
`include "dmb_consts.svh"

module tb_dmb_top
	import dmb_pkg::*;
();

	// Far above the length of all directed tests together
	localparam int TIMEOUT_CYCLES = 3000;
	localparam int N_PATTERNS     = 40;
	localparam int STOP_DELAY     = 17;

	logic      clkcms;
	logic      clr0;
	logic      psel_i;
	logic      penable_i;
	logic      pwrite_i;
	apb_addr_t paddr_i;
	apb_data_t pwdata_i;
	apb_data_t prdata_o;
	logic      pready_o;
	logic      pslverr_o;
	cfeb_vec_t pre_lct_i;
	cfeb_vec_t l1a_match_i;
	logic      l1a_cfeb_i;
	ccbcal_t   ccbcal_i;
	cfeb_vec_t trg_enc_b0_o;
	cfeb_vec_t trg_enc_b1_o;
	cfeb_vec_t trg_enc_b2_o;
	logic      inj_pulse_o;
	logic      ext_pulse_o;
	logic      ctrl_ready_o;

	logic [31:0] rng_state = 32'd20619;
	int          cycle_cnt = 0;

	tb_clkgen #(.PERIOD_NS(40.0)) u_clkgen (.clk_o(clkcms));

	dmb_trig_top u_dmb_trig_top (.*);

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_enc(input string name, input cfeb_vec_t got, input cfeb_vec_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_count(input string name, input tm_count_t got, input tm_count_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// Run length guard
	always @(posedge clkcms)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run("timeout: the directed tests did not finish within the cycle limit");
	end

	////////////////////
	// APB master
	////////////////////

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		@(posedge clkcms);
		psel_i    <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b1;
		paddr_i   <= addr;
		pwdata_i  <= data;
		@(posedge clkcms);
		penable_i <= 1'b1;
		@(negedge clkcms);
		check_bit("pready_o", pready_o, 1'b1);
		err = pslverr_o;
		// Write lands on this edge
		@(posedge clkcms);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		@(posedge clkcms);
		psel_i    <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b0;
		paddr_i   <= addr;
		@(posedge clkcms);
		penable_i <= 1'b1;
		@(negedge clkcms);
		check_bit("pready_o", pready_o, 1'b1);
		data = prdata_o;
		err  = pslverr_o;
		@(posedge clkcms);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
	endtask

	////////////////////
	// Reset and ready
	////////////////////

	task automatic check_idle_outputs();
		check_enc("trg_enc_b0_o", trg_enc_b0_o, '0);
		check_enc("trg_enc_b1_o", trg_enc_b1_o, '0);
		check_enc("trg_enc_b2_o", trg_enc_b2_o, '0);
		check_bit("inj_pulse_o", inj_pulse_o, 1'b0);
		check_bit("ext_pulse_o", ext_pulse_o, 1'b0);
		check_bit("pready_o", pready_o, 1'b0);
		check_bit("pslverr_o", pslverr_o, 1'b0);
		check_bit("ctrl_ready_o", ctrl_ready_o, 1'b0);
	endtask

	// Ends on the edge where clr0 drops, the next edge is edge 1
	task automatic apply_reset();
		int i;
		@(posedge clkcms);
		clr0 <= 1'b1;
		for (i = 0; i < 5; i++)
		begin
			@(negedge clkcms);
			check_idle_outputs();
			@(posedge clkcms);
		end
		clr0 <= 1'b0;
	endtask

	task automatic wait_ready();
		do
		begin
			@(posedge clkcms);
			@(negedge clkcms);
		end
		while (!ctrl_ready_o);
	endtask

	task automatic test_reset_ready();
		apb_data_t rd;
		logic      err;
		int        e;
		for (e = 1; e <= `DMB_READY_CYCLES; e++)
		begin
			@(posedge clkcms);
			@(negedge clkcms);
			if (e < `DMB_READY_CYCLES)
				check_idle_outputs();
			else
				check_bit("ctrl_ready_o", ctrl_ready_o, 1'b1);
		end
		apb_read(`DMB_ADDR_STATUS, rd, err);
		check_bit("pslverr_o", err, 1'b0);
		check_word("STATUS", rd, 32'h1);
	endtask

	////////////////////
	// Register file
	////////////////////

	task automatic test_apb_regs();
		apb_data_t rd;
		apb_data_t wr;
		apb_data_t cfg_rst;
		apb_data_t cfg_mask;
		logic      err;
		cfg_rst  = '0;
		cfg_rst[`DMB_NCFEB-1:0] = '1;
		cfg_mask = (apb_data_t'(1) << (`DMB_NCFEB + 2)) - 1;
		apb_read(`DMB_ADDR_CFG, rd, err);
		check_bit("pslverr_o", err, 1'b0);
		check_word("CFG", rd, cfg_rst);
		rng_state = xorshift32(rng_state);
		wr = rng_state;
		apb_write(`DMB_ADDR_CFG, wr, err);
		check_bit("pslverr_o", err, 1'b0);
		apb_read(`DMB_ADDR_CFG, rd, err);
		check_word("CFG", rd, wr & cfg_mask);
		// Nothing lives at 0x10
		apb_read(8'h10, rd, err);
		check_bit("pslverr_o", err, 1'b1);
		apb_write(`DMB_ADDR_STATUS, 32'h0, err);
		check_bit("pslverr_o", err, 1'b1);
		apb_read(`DMB_ADDR_STATUS, rd, err);
		check_bit("pslverr_o", err, 1'b0);
		check_word("STATUS", rd, 32'h1);
	endtask

	////////////////////
	// Trigger encoder
	////////////////////

	task automatic test_trigger(input logic dly);
		cfeb_vec_t pre_q [N_PATTERNS];
		cfeb_vec_t mat_q [N_PATTERNS];
		logic      l1a_q [N_PATTERNS];
		cfeb_vec_t en;
		cfeb_vec_t exp_b2;
		apb_data_t cfg_word;
		logic      err;
		int        lat;
		int        i;
		int        j;
		rng_state = xorshift32(rng_state);
		en        = rng_state[`DMB_NCFEB-1:0];
		cfg_word  = '0;
		cfg_word[`DMB_NCFEB-1:0] = en;
		cfg_word[`DMB_NCFEB]     = dly;
		apb_write(`DMB_ADDR_CFG, cfg_word, err);
		check_bit("pslverr_o", err, 1'b0);
		repeat (4) @(posedge clkcms);
		// Counted from the driving edge: one to sample, one per output stage
		lat = dly ? 3 : 2;
		for (i = 0; i < N_PATTERNS + lat; i++)
		begin
			@(posedge clkcms);
			if (i < N_PATTERNS)
			begin
				rng_state = xorshift32(rng_state);
				pre_q[i]  = rng_state[`DMB_NCFEB-1:0];
				mat_q[i]  = rng_state[2*`DMB_NCFEB-1:`DMB_NCFEB];
				l1a_q[i]  = rng_state[2*`DMB_NCFEB];
				pre_lct_i   <= pre_q[i];
				l1a_match_i <= mat_q[i];
				l1a_cfeb_i  <= l1a_q[i];
			end
			else
			begin
				pre_lct_i   <= '0;
				l1a_match_i <= '0;
				l1a_cfeb_i  <= 1'b0;
			end
			@(negedge clkcms);
			if (i >= lat)
			begin
				j      = i - lat;
				exp_b2 = l1a_q[j] ? en : '0;
				check_enc("trg_enc_b0_o", trg_enc_b0_o, pre_q[j] & en);
				check_enc("trg_enc_b1_o", trg_enc_b1_o, mat_q[j] & en);
				check_enc("trg_enc_b2_o", trg_enc_b2_o, exp_b2);
			end
		end
	endtask

	////////////////////
	// Calibration
	////////////////////

	task automatic test_inject();
		logic line_q [16];
		int   i;
		for (i = 0; i < 16; i++)
		begin
			@(posedge clkcms);
			rng_state = xorshift32(rng_state);
			line_q[i] = rng_state[0];
			ccbcal_i[1] <= line_q[i];
			@(negedge clkcms);
			if (i >= 2)
				check_bit("inj_pulse_o", inj_pulse_o, ~line_q[i-2]);
		end
		@(posedge clkcms);
		ccbcal_i[1] <= 1'b1;
	endtask

	// Requests five cycles apart, line low for two of them
	task automatic run_requests(input int n_req, input logic alt);
		logic      exp_ext [40];
		logic      phase;
		apb_data_t cfg_word;
		logic      err;
		int        r;
		int        i;
		cfg_word = '0;
		cfg_word[`DMB_NCFEB-1:0] = '1;
		cfg_word[`DMB_NCFEB+1]   = alt;
		apb_write(`DMB_ADDR_CFG, cfg_word, err);
		check_bit("pslverr_o", err, 1'b0);
		repeat (4) @(posedge clkcms);
		exp_ext = '{default: 1'b0};
		phase   = 1'b0;
		for (r = 0; r < n_req; r++)
		begin
			// Sampled one edge after driving, high after N+3 and N+4
			if (!alt || !phase)
			begin
				exp_ext[r*5+4] = 1'b1;
				exp_ext[r*5+5] = 1'b1;
			end
			if (alt)
				phase = ~phase;
		end
		for (i = 0; i < n_req * 5 + 6; i++)
		begin
			@(posedge clkcms);
			ccbcal_i[0] <= ((i % 5) < 2 && i < n_req * 5) ? 1'b0 : 1'b1;
			@(negedge clkcms);
			check_bit("ext_pulse_o", ext_pulse_o, exp_ext[i]);
		end
	endtask

	////////////////////
	// Latency timer
	////////////////////

	task automatic measure_latency(input int gap);
		int i;
		for (i = 0; i <= gap; i++)
		begin
			@(posedge clkcms);
			pre_lct_i[0] <= (i == 0);
			l1a_cfeb_i   <= (i == gap);
		end
		@(posedge clkcms);
		l1a_cfeb_i <= 1'b0;
	endtask

	task automatic test_timer();
		apb_data_t rd;
		logic      err;
		int        i;
		// Start and stop land inside the holdoff window
		apply_reset();
		for (i = 0; i < 8; i++)
		begin
			@(posedge clkcms);
			pre_lct_i[0] <= (i == 1);
			l1a_cfeb_i   <= (i == 5);
		end
		wait_ready();
		apb_read(`DMB_ADDR_TIMER, rd, err);
		check_bit("timer valid", rd[`DMB_TM_WIDTH], 1'b0);
		measure_latency(STOP_DELAY);
		apb_read(`DMB_ADDR_TIMER, rd, err);
		check_count("timer count", rd[`DMB_TM_WIDTH-1:0], tm_count_t'(STOP_DELAY));
		check_bit("timer valid", rd[`DMB_TM_WIDTH], 1'b1);
		// Held value ignores a new start
		measure_latency(5);
		apb_read(`DMB_ADDR_TIMER, rd, err);
		check_count("timer count", rd[`DMB_TM_WIDTH-1:0], tm_count_t'(STOP_DELAY));
		check_bit("timer valid", rd[`DMB_TM_WIDTH], 1'b1);
		rng_state = xorshift32(rng_state);
		apb_write(`DMB_ADDR_TIMER, rng_state, err);
		check_bit("pslverr_o", err, 1'b0);
		apb_read(`DMB_ADDR_TIMER, rd, err);
		check_bit("timer valid", rd[`DMB_TM_WIDTH], 1'b0);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		clr0        <= 1'b1;
		psel_i      <= 1'b0;
		penable_i   <= 1'b0;
		pwrite_i    <= 1'b0;
		paddr_i     <= '0;
		pwdata_i    <= '0;
		pre_lct_i   <= '0;
		l1a_match_i <= '0;
		l1a_cfeb_i  <= 1'b0;
		// CCB lines idle high
		ccbcal_i    <= 3'b111;
		apply_reset();
		test_reset_ready();
		test_apb_regs();
		test_trigger(1'b0);
		test_trigger(1'b1);
		test_inject();
		run_requests(1, 1'b0);
		run_requests(4, 1'b1);
		test_timer();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+hw
hw/dmb_pkg.sv
hw/dmb_ifs.sv
hw/board_ctrl.sv
hw/trig_enc_out.sv
hw/cal_pulse_gen.sv
hw/lct_l1a_timer.sv
hw/dmb_trig_top.sv
tb/tb_clkgen.sv
tb/tb_dmb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_dmb_top \
	-f build.f -o tb_dmb_top_sim &&
./obj_dir/tb_dmb_top_sim | tee /dev/stderr | grep -qx "sim passed" ||
{ echo "simulation did not pass"; exit 1; }
